// ==== src.f ====
design/conv_pkg.sv
design/lane_if.sv
design/packet_alloc.sv
design/conv_pe.sv
design/result_collect.sv
design/conv_array_top.sv
verif/conv_assert.sv
verif/conv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= conv_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/conv_tb.sv ====
module conv_tb;
    import conv_pkg::*;

    localparam int WAIT_LIMIT  = 200;              // Cycles per handshake
    localparam int DRAIN_LIMIT = 4000;

    logic        clk;
    logic        arst_n;
    logic        fil_valid;
    logic        fil_ready;
    fil_pkt_t    fil_data;
    logic        if_valid;
    logic        if_ready;
    if_pkt_t     if_data;
    logic        out_valid;
    logic        out_ready;
    pe_idx_t     out_pe;
    acc_t        out_result;

    logic [31:0] rng_q;
    logic [31:0] stall_q;
    logic        stall_en;
    logic        hold_ifmap;                       // New filter still loading
    logic        hold_filter;                      // Ifmap stream still open
    data_t       w_m [TAPS];                       // Index 0 is the oldest weight
    data_t       hist_m [NUM_PE][TAPS];
    int          cnt_m [NUM_PE];
    acc_t        exp_q [NUM_PE][$];

    conv_array_top dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_q = xorshift32(rng_q);
        return rng_q;
    endfunction

    // First weight meets the oldest pixel
    function automatic acc_t ref_sum(input data_t w0, w1, w2, p0, p1, p2);
        int sum;
        sum = int'(w0) * int'(p0) + int'(w1) * int'(p1) + int'(w2) * int'(p2);
        return acc_t'(sum);
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_result(input acc_t got, input acc_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR at time %0t: result %0d, expected %0d", $time, got, exp));
        end
    endtask

    task automatic check_pe(input pe_idx_t got);
        if (int'(got) >= NUM_PE || exp_q[got].size() == 0) begin
            stop_run($sformatf("ERROR at time %0t: result from element %0d, none expected",
                               $time, got));
        end
    endtask

    // ******************************
    // Stimulus
    // ******************************
    task automatic send_filter(input data_t w, input logic last);
        int cyc;
        cyc       = 0;
        fil_data  = {last, w};
        fil_valid = 1'b1;
        @(posedge clk);
        while (!fil_ready) begin
            if (++cyc > WAIT_LIMIT) stop_run("Timed out waiting for fil_ready");
            @(posedge clk);
        end
        if (hold_filter) stop_run("Filter packet accepted while the ifmap stream was open");
        w_m[0] = w_m[1];
        w_m[1] = w_m[2];
        w_m[2] = w;
        for (int k = 0; k < NUM_PE; k++) begin
            cnt_m[k] = 0;                          // Window refills after any weight
        end
        #1;
        fil_valid = 1'b0;
    endtask

    task automatic send_pixel(input int idx, input data_t pix, input logic last);
        int cyc;
        cyc      = 0;
        if_data  = {last, pe_idx_t'(idx), pix};
        if_valid = 1'b1;
        @(posedge clk);
        while (!if_ready) begin
            if (++cyc > WAIT_LIMIT) stop_run("Timed out waiting for if_ready");
            @(posedge clk);
        end
        if (hold_ifmap) stop_run("Ifmap packet accepted before the new filter was loaded");
        if (idx < NUM_PE) begin                    // 14 and 15 vanish
            hist_m[idx][0] = hist_m[idx][1];
            hist_m[idx][1] = hist_m[idx][2];
            hist_m[idx][2] = pix;
            if (cnt_m[idx] < TAPS) cnt_m[idx]++;
            if (cnt_m[idx] == TAPS) begin
                exp_q[idx].push_back(ref_sum(w_m[0], w_m[1], w_m[2],
                                             hist_m[idx][0], hist_m[idx][1], hist_m[idx][2]));
            end
        end
        #1;
        if_valid = 1'b0;
    endtask

    task automatic load_filter();
        send_filter(data_t'(next_rand()), 1'b0);
        send_filter(data_t'(next_rand()), 1'b0);
        send_filter(data_t'(next_rand()), 1'b1);
    endtask

    task automatic pixel_rounds(input int rounds);
        for (int r = 0; r < rounds; r++) begin
            for (int k = 0; k < NUM_PE; k++) begin
                send_pixel(k, data_t'(next_rand()), 1'b0);
            end
        end
    endtask

    task automatic wait_drain();
        int cyc;
        int pending;
        cyc = 0;
        do begin
            @(negedge clk);
            pending = 0;
            for (int k = 0; k < NUM_PE; k++) begin
                pending += exp_q[k].size();
            end
            if (pending != 0 && ++cyc > DRAIN_LIMIT) stop_run("Timed out waiting for results");
        end while (pending != 0);
        @(posedge clk);
        #1;
    endtask

    // ******************************
    // Compare and stalls
    // ******************************
    always @(posedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            check_pe(out_pe);
            check_result(out_result, exp_q[out_pe].pop_front());
        end
    end

    always @(posedge clk) begin
        #1;
        stall_q   = xorshift32(stall_q);
        out_ready = !stall_en || (stall_q[1:0] != 2'b00);  // Stall one cycle in four
    end

    initial begin
        logic [31:0] r;
        data_t       pix;
        data_t       w;
        clk = 1'b0;
        arst_n = 1'b0;
        fil_valid = 1'b0;
        fil_data = '0;
        if_valid = 1'b0;
        if_data = '0;
        out_ready = 1'b1;
        rng_q = 32'h4727b7c0;
        stall_q = xorshift32(32'h4727b7c0);
        stall_en = 1'b0;
        hold_ifmap = 1'b0;
        hold_filter = 1'b0;
        for (int k = 0; k < NUM_PE; k++) begin
            cnt_m[k] = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        load_filter();                             // Single element, five pixels
        repeat (5) send_pixel(0, data_t'(next_rand()), 1'b0);
        wait_drain();
        repeat (20) @(posedge clk);                // Room for a stray fourth result
        #1;

        stall_en = 1'b1;                           // Random order, bad indexes, stalls
        repeat (300) begin
            r = next_rand();
            send_pixel(int'(r[11:8]), r[7:0], 1'b0);
        end
        send_pixel(5, data_t'(next_rand()), 1'b1);
        wait_drain();

        pix = data_t'(next_rand());                // Pixel offered ahead of the reload
        hold_ifmap = 1'b1;
        fork
            begin
                load_filter();
                hold_ifmap = 1'b0;
            end
            send_pixel(3, pix, 1'b0);
        join
        pixel_rounds(3);
        wait_drain();

        w = data_t'(next_rand());                  // Filter offered in ifmap mode
        hold_filter = 1'b1;
        fork
            begin
                for (int k = 0; k < NUM_PE; k++) begin
                    send_pixel(k, data_t'(next_rand()), k == NUM_PE - 1);
                end
                hold_filter = 1'b0;
            end
            send_filter(w, 1'b0);
        join
        send_filter(data_t'(next_rand()), 1'b0);
        send_filter(data_t'(next_rand()), 1'b1);
        pixel_rounds(3);
        wait_drain();
        repeat (20) @(posedge clk);

        if (out_valid) begin
            stop_run("An unexpected result is left in the output register");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== verif/conv_assert.sv ====
module conv_assert (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        fil_ready,
    input logic                        if_ready,
    input logic                        out_valid,
    input logic                        out_ready,
    input logic [conv_pkg::IDX_W-1:0]  out_pe,
    input logic [conv_pkg::ACC_W-1:0]  out_result,
    input conv_pkg::pe_mask_t          lane_valid
);

    // ******************************
    // Handshake rules
    // ******************************
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_pe))
        else $error("Output changed while stalled");

    ready_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(fil_ready && if_ready))
        else $error("Filter and ifmap ready together");

    lane_reset: assert property (@(posedge clk)
        !arst_n |-> lane_valid == '0)
        else $error("Lane valid during reset");

endmodule

bind conv_array_top conv_assert u_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .fil_ready  (fil_ready),
    .if_ready   (if_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_pe     (out_pe),
    .out_result (out_result),
    .lane_valid (u_alloc.pend_q)                   // Pending mask drives the lane valids
);

// ==== design/conv_array_top.sv ====
module conv_array_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       fil_valid,
    output logic                       fil_ready,
    input  logic [conv_pkg::FIL_W-1:0] fil_data,
    input  logic                       if_valid,
    output logic                       if_ready,
    input  logic [conv_pkg::IF_W-1:0]  if_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [conv_pkg::IDX_W-1:0] out_pe,
    output logic [conv_pkg::ACC_W-1:0] out_result
);
    import conv_pkg::*;

    lane_if   lanes [NUM_PE-1:0] ();

    pe_mask_t res_valid;
    pe_mask_t res_ready;
    acc_t     res_data [NUM_PE-1:0];

    // ******************************
    // Input side
    // ******************************
    packet_alloc u_alloc (
        .clk       (clk),
        .arst_n    (arst_n),
        .fil_valid (fil_valid),
        .fil_ready (fil_ready),
        .fil_data  (fil_data),
        .if_valid  (if_valid),
        .if_ready  (if_ready),
        .if_data   (if_data),
        .lanes     (lanes)
    );

    // ******************************
    // Element array
    // ******************************
    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        conv_pe u_pe (
            .clk       (clk),
            .arst_n    (arst_n),
            .lane      (lanes[i]),
            .res_valid (res_valid[i]),
            .res_ready (res_ready[i]),
            .res_data  (res_data[i])
        );
    end

    // ******************************
    // Output side
    // ******************************
    result_collect u_collect (
        .clk        (clk),
        .arst_n     (arst_n),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_data   (res_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pe     (out_pe),
        .out_result (out_result)
    );

endmodule

// ==== design/result_collect.sv ====
module result_collect (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [conv_pkg::NUM_PE-1:0] res_valid,
    output logic [conv_pkg::NUM_PE-1:0] res_ready,
    input  conv_pkg::acc_t              res_data [conv_pkg::NUM_PE-1:0],
    output logic                        out_valid,
    input  logic                        out_ready,
    output conv_pkg::pe_idx_t           out_pe,
    output conv_pkg::acc_t              out_result
);
    import conv_pkg::*;

    pe_idx_t last_q;                               // Last granted element
    pe_idx_t gnt_idx;
    logic    found;
    logic    load;
    logic    grant;

    assign load  = !out_valid || out_ready;        // Empty or draining
    assign grant = found && load;

    // ******************************
    // Round-robin search
    // ******************************
    always_comb begin
        int cand;
        found   = 1'b0;
        gnt_idx = last_q;
        for (int k = 1; k <= NUM_PE; k++) begin
            cand = int'(last_q) + k;
            if (cand >= NUM_PE) begin
                cand = cand - NUM_PE;
            end
            if (!found && res_valid[cand]) begin
                found   = 1'b1;
                gnt_idx = pe_idx_t'(cand);
            end
        end
    end

    always_comb begin
        res_ready = '0;
        if (grant) begin
            res_ready[gnt_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            last_q    <= pe_idx_t'(NUM_PE - 1);    // Element 0 goes first
        end else if (grant) begin
            out_valid <= 1'b1;
            last_q    <= gnt_idx;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            out_pe     <= gnt_idx;
            out_result <= res_data[gnt_idx];
        end
    end

endmodule

// ==== design/conv_pe.sv ====
module conv_pe (
    input  logic           clk,
    input  logic           arst_n,
    lane_if.dst            lane,
    output logic           res_valid,
    input  logic           res_ready,
    output conv_pkg::acc_t res_data
);
    import conv_pkg::*;

    data_t     w_q [TAPS];                         // Index 0 is the oldest weight
    data_t     px_q [TAPS-1];                      // Previous pixels, index 0 oldest
    data_t     win_c [TAPS];
    fill_cnt_t cnt_q;
    acc_t      sum_c;

    logic      take_w;
    logic      take_px;
    logic      win_full;

    // Weights wait for an empty result register
    assign lane.ready = lane.is_weight ? !res_valid : (!res_valid || res_ready);

    assign take_w   = lane.valid && lane.ready && lane.is_weight;
    assign take_px  = lane.valid && lane.ready && !lane.is_weight;
    assign win_full = int'(cnt_q) >= TAPS - 1;     // Incoming pixel makes three

    // ******************************
    // Window and sum
    // ******************************
    always_comb begin
        for (int k = 0; k < TAPS - 1; k++) begin
            win_c[k] = px_q[k];
        end
        win_c[TAPS-1] = lane.data;                 // Newest pixel meets newest tap
        sum_c = '0;
        for (int k = 0; k < TAPS; k++) begin
            sum_c = sum_c + acc_t'(w_q[k]) * acc_t'(win_c[k]);
        end
    end

    // ******************************
    // Control
    // ******************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q     <= '0;
            res_valid <= 1'b0;
        end else begin
            if (take_w) begin
                cnt_q <= '0;                       // New filter, refill the window
            end else if (take_px && int'(cnt_q) < TAPS) begin
                cnt_q <= cnt_q + 1'b1;
            end

            if (take_px && win_full) begin
                res_valid <= 1'b1;
            end else if (res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    // ******************************
    // Taps, history, result
    // ******************************
    always_ff @(posedge clk) begin
        if (take_w) begin
            for (int k = 0; k < TAPS - 1; k++) begin
                w_q[k] <= w_q[k+1];
            end
            w_q[TAPS-1] <= lane.data;
        end
        if (take_px) begin
            for (int k = 0; k < TAPS - 1; k++) begin
                px_q[k] <= win_c[k+1];
            end
            if (win_full) begin
                res_data <= sum_c;
            end
        end
    end

endmodule

// ==== design/packet_alloc.sv ====
module packet_alloc (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              fil_valid,
    output logic              fil_ready,
    input  conv_pkg::fil_pkt_t fil_data,
    input  logic              if_valid,
    output logic              if_ready,
    input  conv_pkg::if_pkt_t if_data,
    lane_if.src               lanes [conv_pkg::NUM_PE-1:0]
);
    import conv_pkg::*;

    alloc_state_t state_q;
    alloc_state_t state_d;
    pe_mask_t     pend_q;                          // Lanes still owed the held packet
    pe_mask_t     pend_d;
    pe_mask_t     lane_rdy;
    logic         is_weight_q;
    data_t        data_q;

    logic         stage_free;
    logic         fil_acc;
    logic         if_acc;
    logic         fil_last;
    logic         if_last;
    pe_idx_t      if_idx;
    logic         idx_ok;

    assign fil_last = fil_data[FIL_LAST];
    assign if_last  = if_data[IF_LAST];
    assign if_idx   = if_data[IF_IDX_LSB +: IDX_W];
    assign idx_ok   = int'(if_idx) < NUM_PE;       // 14 and 15 are dropped

    // Stage frees once every pending lane has taken the packet
    assign stage_free = (pend_q & ~lane_rdy) == '0;

    assign fil_ready = (state_q == FILTER_MODE) && (pend_q == '0);
    assign if_ready  = (state_q == IFMAP_MODE) && stage_free;
    assign fil_acc   = fil_valid && fil_ready;
    assign if_acc    = if_valid && if_ready;

    // ******************************
    // Lane drive
    // ******************************
    for (genvar i = 0; i < NUM_PE; i++) begin : g_lane
        assign lanes[i].valid     = pend_q[i];
        assign lanes[i].is_weight = is_weight_q;
        assign lanes[i].data      = data_q;
        assign lane_rdy[i]        = lanes[i].ready;
    end

    // ******************************
    // Mode and pending mask
    // ******************************
    always_comb begin
        state_d = state_q;
        pend_d  = pend_q & ~lane_rdy;              // Drop lanes that took it
        if (fil_acc) begin
            pend_d = '1;                           // Broadcast
            if (fil_last) begin
                state_d = IFMAP_MODE;
            end
        end else if (if_acc) begin
            pend_d = idx_ok ? (pe_mask_t'(1) << if_idx) : '0;
            if (if_last) begin
                state_d = FILTER_MODE;             // Ready for a new filter
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= FILTER_MODE;
            pend_q  <= '0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_d;
        end
    end

    always_ff @(posedge clk) begin
        if (fil_acc) begin
            data_q      <= fil_data[DATA_W-1:0];
            is_weight_q <= 1'b1;
        end else if (if_acc) begin
            data_q      <= if_data[DATA_W-1:0];
            is_weight_q <= 1'b0;
        end
    end

endmodule

// ==== design/lane_if.sv ====
interface lane_if;
    import conv_pkg::*;

    logic  valid;
    logic  ready;
    logic  is_weight;                              // High for a broadcast weight
    data_t data;

    modport src (
        output valid,
        output is_weight,
        output data,
        input  ready
    );

    modport dst (
        input  valid,
        input  is_weight,
        input  data,
        output ready
    );

endinterface

// ==== design/conv_pkg.sv ====
package conv_pkg;

    // ******************************
    // Sizes
    // ******************************
    localparam int NUM_PE = 14;                    // Processing elements
    localparam int TAPS   = 3;                     // Filter and window length

    localparam int DATA_W = 8;                     // Weight or pixel
    localparam int IDX_W  = 4;                     // Element index
    localparam int ACC_W  = 18;                    // Three 16-bit products
    localparam int CNT_W  = 2;                     // Window fill count, 0..TAPS

    // ******************************
    // Packet fields
    // ******************************
    localparam int FIL_W       = DATA_W + 1;       // last | weight
    localparam int IF_W        = IDX_W + DATA_W + 1;  // last | index | pixel
    localparam int FIL_LAST    = FIL_W - 1;
    localparam int IF_LAST     = IF_W - 1;
    localparam int IF_IDX_LSB  = DATA_W;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [IDX_W-1:0]  pe_idx_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [FIL_W-1:0]  fil_pkt_t;
    typedef logic [IF_W-1:0]   if_pkt_t;
    typedef logic [NUM_PE-1:0] pe_mask_t;      // One bit per lane
    typedef logic [CNT_W-1:0]  fill_cnt_t;

    typedef enum logic {
        FILTER_MODE,                               // Weights broadcast to all lanes
        IFMAP_MODE                                 // Pixels steered by index
    } alloc_state_t;

endpackage
